//--- verilog/fetch_pkg.sv
// fetch front end definitions
package fetch_pkg;

  // ==================================================
  // widths and types
  // ==================================================

  // byte address, also the program counter
  typedef logic [63:0] addr_t;

  // one instruction memory word, two instructions wide
  typedef logic [63:0] word_t;

  typedef logic [31:0] inst_t;

  // read response code on the data channel
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // ==================================================
  // fetch unit
  // ==================================================

  localparam addr_t RESET_PC = 64'h8000_0000;

  // read machine, one outstanding read at most
  typedef enum logic {
    ST_IDLE,
    ST_WAIT_DATA
  } fetch_state_e;

  // ==================================================
  // instruction memory
  // ==================================================

  // depth in 64-bit words, as a power of two
  localparam int ROM_DEPTH_LOG2 = 8;

  typedef logic [ROM_DEPTH_LOG2-1:0] rom_idx_t;

  // cycles from address accept to rvalid
  localparam int ROM_LATENCY = 2;

  typedef logic [$clog2(ROM_LATENCY+1)-1:0] lat_cnt_t;

  // ==================================================
  // jump detection
  // ==================================================

  localparam logic [6:0] OPC_JAL = 7'b1101111;

endpackage

//--- verilog/axi_rd_if.sv
// read channel interface
`timescale 1ns/1ps

interface axi_rd_if;

  // read address channel
  logic               arvalid;
  logic               arready;
  fetch_pkg::addr_t   araddr;

  // read data channel, single beat per address
  logic               rvalid;
  logic               rready;
  fetch_pkg::word_t   rdata;
  fetch_pkg::resp_t   rresp;

  // fetch unit side
  modport master (
    output arvalid,
    output araddr,
    output rready,
    input  arready,
    input  rvalid,
    input  rdata,
    input  rresp
  );

  // memory side
  modport slave (
    input  arvalid,
    input  araddr,
    input  rready,
    output arready,
    output rvalid,
    output rdata,
    output rresp
  );

endinterface

//--- verilog/ifu.sv
// instruction fetch unit
`timescale 1ns/1ps

module ifu (
  input  logic               clk,
  input  logic               rst_n,

  // redirect from the jump unit
  input  logic               jump_i,
  input  fetch_pkg::addr_t   jump_target_i,

  // back-pressure from the next stage
  input  logic               stall_i,

  axi_rd_if.master           mem,

  // one pulse per committed instruction
  output logic               commit_o,
  output fetch_pkg::inst_t   inst_o,
  output fetch_pkg::addr_t   inst_pc_o
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;

  fetch_pkg::addr_t pc_q;

  // last read response, kept for inspection only
  fetch_pkg::resp_t resp_q;

  logic ar_fire;
  logic r_fire;

  // ==================================================
  // handshakes
  // ==================================================

  assign ar_fire = mem.arvalid && mem.arready;

  // no data taken while the next stage is stalled
  assign mem.rready = (state_q == fetch_pkg::ST_WAIT_DATA) && !stall_i;

  assign r_fire = mem.rready && mem.rvalid;

  // ==================================================
  // read state machine
  // ==================================================

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fetch_pkg::ST_IDLE: begin
        if (ar_fire) begin
          state_d = fetch_pkg::ST_WAIT_DATA;
        end
      end
      fetch_pkg::ST_WAIT_DATA: begin
        if (r_fire) begin
          state_d = fetch_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = fetch_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q     <= fetch_pkg::ST_IDLE;
      // address request already up right out of reset
      mem.arvalid <= 1'b1;
    end else begin
      state_q     <= state_d;
      mem.arvalid <= (state_d == fetch_pkg::ST_IDLE);
    end
  end

  // ==================================================
  // program counter
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= fetch_pkg::RESET_PC;
    end else if (jump_i) begin
      pc_q <= jump_target_i;
    end else if (r_fire) begin
      pc_q <= pc_q + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      resp_q <= fetch_pkg::RESP_OKAY;
    end else if (r_fire) begin
      resp_q <= mem.rresp;
    end
  end

  // redirect takes effect on the bus in the same cycle
  assign mem.araddr = jump_i ? jump_target_i : pc_q;

  // ==================================================
  // commit
  // ==================================================

  assign commit_o  = r_fire;
  // bit 2 picks the half of the 64-bit word
  assign inst_o    = pc_q[2] ? mem.rdata[63:32] : mem.rdata[31:0];
  assign inst_pc_o = pc_q;

  // redirect only arrives between reads
  a_jump_idle: assert property (@(posedge clk) disable iff (rst_n)
    jump_i |-> state_q == fetch_pkg::ST_IDLE);

  a_ar_r_exclusive: assert property (@(posedge clk) disable iff (rst_n)
    !(mem.arvalid && mem.rready));

  // memory never answers with an error
  a_resp_okay: assert property (@(posedge clk) disable iff (rst_n)
    resp_q == fetch_pkg::RESP_OKAY);

endmodule

//--- verilog/inst_rom.sv
// instruction memory read slave
`timescale 1ns/1ps

module inst_rom (
  input  logic                 clk,
  input  logic                 rst_n,

  axi_rd_if.slave              bus,

  // program load, used while fetch is held in reset
  input  logic                 prog_we_i,
  input  fetch_pkg::rom_idx_t  prog_idx_i,
  input  fetch_pkg::word_t     prog_data_i
);

  fetch_pkg::word_t mem_q [2**fetch_pkg::ROM_DEPTH_LOG2];

  // word index of the presented address, wraps with the depth
  fetch_pkg::rom_idx_t rd_idx;

  logic                busy_q;
  fetch_pkg::lat_cnt_t lat_cnt_q;
  fetch_pkg::word_t    rdata_q;

  logic ar_fire;
  logic r_fire;

  // ==================================================
  // handshakes
  // ==================================================

  assign rd_idx  = bus.araddr[fetch_pkg::ROM_DEPTH_LOG2+2:3];

  // one read at a time
  assign bus.arready = !busy_q;

  assign ar_fire = bus.arvalid && bus.arready;
  assign r_fire  = bus.rvalid && bus.rready;

  // ==================================================
  // latency counter
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      busy_q    <= 1'b0;
      lat_cnt_q <= '0;
    end else if (ar_fire) begin
      busy_q    <= 1'b1;
      lat_cnt_q <= fetch_pkg::lat_cnt_t'(fetch_pkg::ROM_LATENCY - 1);
    end else if (busy_q) begin
      if (lat_cnt_q != '0) begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
      end else if (r_fire) begin
        busy_q <= 1'b0;
      end
    end
  end

  // ==================================================
  // storage
  // ==================================================

  always_ff @(posedge clk) begin
    if (prog_we_i) begin
      mem_q[prog_idx_i] <= prog_data_i;
    end
  end

  // word captured at accept, held until the beat goes out
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= mem_q[rd_idx];
    end
  end

  assign bus.rvalid = busy_q && (lat_cnt_q == '0);
  assign bus.rdata  = rdata_q;
  assign bus.rresp  = fetch_pkg::RESP_OKAY;

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst_n)
    bus.rvalid && !bus.rready |=> bus.rvalid);

  a_rdata_stable: assert property (@(posedge clk) disable iff (rst_n)
    bus.rvalid && !bus.rready |=> $stable(bus.rdata));

endmodule

//--- verilog/jump_unit.sv
// if/id register and jal redirect
`timescale 1ns/1ps

module jump_unit (
  input  logic               clk,
  input  logic               rst_n,

  // from the fetch unit
  input  logic               commit_i,
  input  fetch_pkg::inst_t   inst_i,
  input  fetch_pkg::addr_t   pc_i,

  input  logic               stall_i,

  // register contents for the decode stage
  output logic               valid_o,
  output fetch_pkg::inst_t   inst_o,
  output fetch_pkg::addr_t   pc_o,

  // redirect back to the fetch unit
  output logic               jump_o,
  output fetch_pkg::addr_t   jump_target_o
);

  logic             valid_q;
  fetch_pkg::inst_t inst_q;
  fetch_pkg::addr_t pc_q;

  // entry loaded on the last edge
  logic             first_q;

  logic             is_jal;
  fetch_pkg::addr_t jal_imm;

  // ==================================================
  // if/id register
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= 1'b0;
    end else if (stall_i) begin
      valid_q <= valid_q;
    end else begin
      // valid only for the cycle after a commit
      valid_q <= commit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_i && !stall_i) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // redirect pulse goes out once per entry, stall or not
  always_ff @(posedge clk) begin
    if (rst_n) begin
      first_q <= 1'b0;
    end else begin
      first_q <= commit_i && !stall_i;
    end
  end

  // ==================================================
  // jal detection
  // ==================================================

  assign is_jal = (inst_q[6:0] == fetch_pkg::OPC_JAL);

  // j-type immediate, sign extended
  assign jal_imm = {
    {44{inst_q[31]}},
    inst_q[19:12],
    inst_q[20],
    inst_q[30:21],
    1'b0
  };

  assign jump_o        = valid_q && first_q && is_jal;
  assign jump_target_o = pc_q + jal_imm;

  assign valid_o = valid_q;
  assign inst_o  = inst_q;
  assign pc_o    = pc_q;

  // fetch does not commit into a stalled stage
  a_no_commit_in_stall: assert property (@(posedge clk) disable iff (rst_n)
    commit_i |-> !stall_i);

endmodule

//--- verilog/fetch_top.sv
// fetch front end top level
`timescale 1ns/1ps

module fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 stall_i,

  // program load port
  input  logic                 prog_we_i,
  input  fetch_pkg::rom_idx_t  prog_idx_i,
  input  fetch_pkg::word_t     prog_data_i,

  // if/id register contents
  output logic                 fetch_valid_o,
  output fetch_pkg::inst_t     fetch_inst_o,
  output fetch_pkg::addr_t     fetch_pc_o
);

  // fetch to jump unit
  logic             commit;
  fetch_pkg::inst_t commit_inst;
  fetch_pkg::addr_t commit_pc;

  // jump unit back to fetch
  logic             jump;
  fetch_pkg::addr_t jump_target;

  // ==================================================
  // instruction read channel
  // ==================================================

  axi_rd_if u_bus ();

  ifu u_ifu (
    .clk           (clk),
    .rst_n         (rst_n),
    .jump_i        (jump),
    .jump_target_i (jump_target),
    .stall_i       (stall_i),
    .mem           (u_bus.master),
    .commit_o      (commit),
    .inst_o        (commit_inst),
    .inst_pc_o     (commit_pc)
  );

  inst_rom u_rom (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (u_bus.slave),
    .prog_we_i   (prog_we_i),
    .prog_idx_i  (prog_idx_i),
    .prog_data_i (prog_data_i)
  );

  // ==================================================
  // if/id stage
  // ==================================================

  jump_unit u_jump (
    .clk           (clk),
    .rst_n         (rst_n),
    .commit_i      (commit),
    .inst_i        (commit_inst),
    .pc_i          (commit_pc),
    .stall_i       (stall_i),
    .valid_o       (fetch_valid_o),
    .inst_o        (fetch_inst_o),
    .pc_o          (fetch_pc_o),
    .jump_o        (jump),
    .jump_target_o (jump_target)
  );

endmodule

//--- tests/fetch_tb.sv
// fetch front end testbench
`timescale 1ns/1ps

module fetch_tb;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS = 4;
  localparam int ENTRIES_PER_TEST = 500;
  localparam int NUM_WORDS = 2**fetch_pkg::ROM_DEPTH_LOG2;
  localparam int NUM_SLOTS = 2 * NUM_WORDS;
  // worst case per entry plus reset and program load for every test
  localparam int CYCLE_LIMIT = NUM_TESTS * ENTRIES_PER_TEST * (fetch_pkg::ROM_LATENCY + 4 + 6)
                               + NUM_TESTS * (RESET_CYCLES + NUM_WORDS + 2);

  logic                clk;
  logic                rst_n;
  logic                stall_i;
  logic                prog_we_i;
  fetch_pkg::rom_idx_t prog_idx_i;
  fetch_pkg::word_t    prog_data_i;
  logic                fetch_valid_o;
  fetch_pkg::inst_t    fetch_inst_o;
  fetch_pkg::addr_t    fetch_pc_o;

  // program copy as loaded and split by instruction slot
  fetch_pkg::word_t prog_words [NUM_WORDS];
  fetch_pkg::inst_t prog_insts [NUM_SLOTS];
  // jal byte offset per slot, zero for no jal
  int               jal_off [NUM_SLOTS];

  logic [31:0] lcg_state;
  int          burst_left;
  int          checks;
  int          errors;

  fetch_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .prog_we_i     (prog_we_i),
    .prog_idx_i    (prog_idx_i),
    .prog_data_i   (prog_data_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_inst_o  (fetch_inst_o),
    .fetch_pc_o    (fetch_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==================================================
  // random numbers
  // ==================================================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // the upper bits repeat less often than the low ones
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8] % n);
  endfunction

  // ==================================================
  // compare tasks
  // ==================================================

  task automatic compare_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_inst(input string name, input fetch_pkg::inst_t got,
                              input fetch_pkg::inst_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ==================================================
  // program generation and load
  // ==================================================

  // j-type layout of a byte offset
  function automatic fetch_pkg::inst_t encode_jal(input int off, input logic [4:0] rd);
    logic [20:0] imm;
    imm = 21'(off);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, fetch_pkg::OPC_JAL};
  endfunction

  task automatic load_program(input bit use_jal);
    fetch_pkg::inst_t ins;
    int               off;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      jal_off[s] = 0;
      if (use_jal && rand_below(8) == 0) begin
        // word aligned offset within one KiB either way
        off = (rand_below(511) - 255) * 4;
        if (off == 0) begin
          off = 4;
        end
        jal_off[s] = off;
        ins = encode_jal(off, 5'(rand_below(32)));
      end else begin
        ins = lcg_next();
        if (ins[6:0] == fetch_pkg::OPC_JAL) begin
          ins[0] = ~ins[0];
        end
      end
      prog_insts[s] = ins;
      prog_words[s / 2][32 * (s % 2) +: 32] = ins;
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      @(negedge clk);
      prog_we_i   = 1'b1;
      prog_idx_i  = fetch_pkg::rom_idx_t'(i);
      prog_data_i = prog_words[i];
    end
    @(negedge clk);
    prog_we_i = 1'b0;
  endtask

  // ==================================================
  // stall pattern and test run
  // ==================================================

  task automatic drive_stall(input bit use_stall);
    if (!use_stall) begin
      stall_i = 1'b0;
    end else if (burst_left > 0) begin
      stall_i = 1'b1;
      burst_left--;
    end else if (rand_below(8) == 0) begin
      // burst of one to six cycles
      stall_i = 1'b1;
      burst_left = rand_below(6);
    end else begin
      stall_i = 1'b0;
    end
  endtask

  task automatic run_test(input int id, input string name, input bit use_jal,
                          input bit use_stall);
    fetch_pkg::addr_t exp_pc;
    fetch_pkg::inst_t exp_inst;
    fetch_pkg::addr_t prev_pc;
    fetch_pkg::inst_t prev_inst;
    logic             prev_valid;
    bit               have_prev;
    longint           off_l;
    int               slot;
    int               entries;
    int               jumps;
    int               errors_before;
    errors_before = errors;
    entries = 0;
    jumps = 0;
    have_prev = 1'b0;
    burst_left = 0;
    @(negedge clk);
    rst_n = 1'b1;
    stall_i = 1'b0;
    load_program(use_jal);
    repeat (RESET_CYCLES) @(negedge clk);
    compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    rst_n = 1'b0;
    exp_pc = fetch_pkg::RESET_PC;
    while (entries < ENTRIES_PER_TEST) begin
      @(negedge clk);
      // stall_i here is the value seen by the last rising edge
      if (have_prev && stall_i) begin
        compare_bit("fetch_valid_o", fetch_valid_o, prev_valid);
        compare_addr("fetch_pc_o", fetch_pc_o, prev_pc);
        compare_inst("fetch_inst_o", fetch_inst_o, prev_inst);
      end
      if (fetch_valid_o && !stall_i) begin
        // slot index wraps with the memory depth
        slot = int'(exp_pc[fetch_pkg::ROM_DEPTH_LOG2+2:2]);
        exp_inst = prog_insts[slot];
        compare_addr("fetch_pc_o", fetch_pc_o, exp_pc);
        compare_inst("fetch_inst_o", fetch_inst_o, exp_inst);
        if (jal_off[slot] != 0) begin
          off_l = jal_off[slot];
          exp_pc = exp_pc + fetch_pkg::addr_t'(off_l);
          jumps++;
        end else begin
          exp_pc = exp_pc + 64'd4;
        end
        entries++;
      end
      prev_valid = fetch_valid_o;
      prev_pc = fetch_pc_o;
      prev_inst = fetch_inst_o;
      have_prev = 1'b1;
      drive_stall(use_stall);
    end
    $display("test %0d %s: %0d entries, %0d jumps, %0d errors", id, name, entries, jumps,
             errors - errors_before);
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================

  initial begin
    rst_n = 1'b1;
    stall_i = 1'b0;
    prog_we_i = 1'b0;
    prog_idx_i = '0;
    prog_data_i = '0;
    lcg_state = 32'haf0f72b9;
    checks = 0;
    errors = 0;
    run_test(1, "sequential with stalls", 1'b0, 1'b1);
    run_test(2, "jumps without stalls", 1'b1, 1'b0);
    run_test(3, "jumps with stalls", 1'b1, 1'b1);
    run_test(4, "jumps with stalls again", 1'b1, 1'b1);
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (CYCLE_LIMIT) @(posedge clk);
    $display("timeout after %0d cycles, the fetch stream did not deliver all entries",
             CYCLE_LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- vlog.f
verilog/fetch_pkg.sv
verilog/axi_rd_if.sv
verilog/ifu.sv
verilog/inst_rom.sv
verilog/jump_unit.sv
verilog/fetch_top.sv
tests/fetch_tb.sv
